// ==== design/basics_responder.sv ====
`timescale 1ns/100ps
`include "ice_bus_consts.svh"

module basics_responder
	import ice_bus_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	ma_bus_if.device ma,
	sl_bus_if.device sl
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_COLLECT,
		ST_SEND
	} state_e;

	state_e    state;
	ice_char_t idx;
	ice_char_t len_q;
	logic      is_echo;
	logic      take;
	ice_char_t echo_head;
	logic      echo_empty;
	logic      echo_full;
	logic      echo_push;
	logic      echo_pop;

	// Echo payload buffer, one full frame
	ice_fifo #(
		.item_t(ice_char_t),
		.DEPTH (`ICE_MAX_LEN + 1)
	) u_echo_fifo (
		.clk      (clk),
		.rst_n    (rst_n),
		.push     (echo_push),
		.push_item(ma.ma_data),
		.pop      (echo_pop),
		.head     (echo_head),
		.empty    (echo_empty),
		.full     (echo_full)
	);

	assign take      = sl.sl_grant && sl.sl_data_latch;
	assign echo_push = ma.ma_data_valid && is_echo && (state == ST_COLLECT) && !echo_full;
	// Bytes from index 2 on come out of the FIFO
	assign echo_pop  = take && is_echo && (idx >= 8'd2) && !echo_empty;

	assign sl.sl_request = (state == ST_SEND);
	assign sl.sl_last    = is_echo ? (idx == len_q + 8'd1) : (idx == 8'd3);

	// Response byte at the current index
	always_comb begin
		if (is_echo) begin
			case (idx)
				8'd0:    sl.sl_data = `ICE_ADDR_ECHO;
				8'd1:    sl.sl_data = len_q;
				default: sl.sl_data = echo_head;
			endcase
		end else begin
			case (idx)
				8'd0:    sl.sl_data = `ICE_ADDR_QUERY;
				8'd1:    sl.sl_data = `ICE_QUERY_LEN;
				8'd2:    sl.sl_data = `ICE_VERSION;
				default: sl.sl_data = 8'(`ICE_NUM_DEV);
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= ST_IDLE;
			idx     <= '0;
			len_q   <= '0;
			is_echo <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: if (ma.ma_frame_valid && ma.ma_kind != KIND_NAK) begin
					is_echo <= (ma.ma_kind == KIND_ECHO);
					len_q   <= ma.ma_len;
					state   <= ST_COLLECT;
				end
				// Answer only once the frame has closed
				ST_COLLECT: if (!ma.ma_frame_valid) begin
					idx   <= '0;
					state <= ST_SEND;
				end
				ST_SEND: if (take) begin
					if (sl.sl_last)
						state <= ST_IDLE;
					else
						idx <= idx + 8'd1;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// ==== design/frame_parser.sv ====
`timescale 1ns/100ps
`include "ice_bus_consts.svh"

module frame_parser
	import ice_bus_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  ice_char_t rx_char,
	input  logic      rx_char_valid,
	ma_bus_if.master  ma
);

	typedef enum logic [1:0] {
		ST_ADDR,
		ST_LEN,
		ST_DATA
	} state_e;

	state_e      state;
	ice_char_t   remaining;
	frame_kind_e kind_d;
	nak_reason_e reason_d;

	// Kind decode from the stored address and the incoming length
	// Bad address wins over bad length
	always_comb begin
		kind_d   = KIND_NAK;
		reason_d = NAK_BAD_ADDR;
		if (ma.ma_addr == `ICE_ADDR_QUERY)
			kind_d = KIND_QUERY;
		else if (ma.ma_addr == `ICE_ADDR_ECHO)
			kind_d = KIND_ECHO;
		if (kind_d != KIND_NAK && rx_char > `ICE_MAX_LEN) begin
			kind_d   = KIND_NAK;
			reason_d = NAK_TOO_LONG;
		end
	end

	// Frame FSM and bus strobes
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state             <= ST_ADDR;
			remaining         <= '0;
			ma.ma_frame_valid <= 1'b0;
			ma.ma_data_valid  <= 1'b0;
			ma.generate_nak   <= 1'b0;
		end else begin
			// Strobes last one cycle
			ma.ma_data_valid <= 1'b0;
			ma.generate_nak  <= 1'b0;
			case (state)
				ST_ADDR: begin
					// Frame ended last cycle, close it here
					ma.ma_frame_valid <= 1'b0;
					if (rx_char_valid)
						state <= ST_LEN;
				end
				ST_LEN: if (rx_char_valid) begin
					ma.ma_frame_valid <= 1'b1;
					ma.generate_nak   <= (kind_d == KIND_NAK);
					remaining         <= rx_char;
					// Zero length, frame is one cycle
					state <= (rx_char == 8'd0) ? ST_ADDR : ST_DATA;
				end
				ST_DATA: if (rx_char_valid) begin
					// NAK payload swallowed
					ma.ma_data_valid <= (ma.ma_kind != KIND_NAK);
					remaining        <= remaining - 8'd1;
					if (remaining == 8'd1)
						state <= ST_ADDR;
				end
				default: state <= ST_ADDR;
			endcase
		end
	end

	// Header and payload fields
	always_ff @(posedge clk) begin
		if (rx_char_valid) begin
			case (state)
				ST_ADDR: ma.ma_addr <= rx_char;
				ST_LEN: begin
					ma.ma_kind    <= kind_d;
					ma.ma_len     <= rx_char;
					ma.nak_reason <= reason_d;
				end
				default: ma.ma_data <= rx_char;
			endcase
		end
	end

endmodule

// ==== design/ice_bus_consts.svh ====
`ifndef ICE_BUS_CONSTS_SVH
`define ICE_BUS_CONSTS_SVH

// Frame limits
`define ICE_MAX_LEN     8'd15
`define ICE_NUM_DEV     2
`define ICE_NAK_DEPTH   4

// Device addresses, 'V' and 'E'
`define ICE_ADDR_QUERY  8'h56
`define ICE_ADDR_ECHO   8'h45

// Response bytes
`define ICE_NAK_CHAR    8'h4e
`define ICE_VERSION     8'h13
`define ICE_QUERY_LEN   8'd2

`endif

// ==== design/ice_bus_if.sv ====
`timescale 1ns/100ps

// Master bus, parser to all devices
interface ma_bus_if import ice_bus_pkg::*; ();
	// Header fields, stable for the whole frame
	ice_char_t   ma_addr;
	frame_kind_e ma_kind;
	ice_char_t   ma_len;
	// Payload byte and its strobe
	ice_char_t   ma_data;
	logic        ma_data_valid;
	logic        ma_frame_valid;
	// NAK pulse and its reason
	logic        generate_nak;
	nak_reason_e nak_reason;

	modport master (output ma_addr, ma_kind, ma_len, ma_data, ma_data_valid,
		ma_frame_valid, generate_nak, nak_reason);
	modport device (input ma_addr, ma_kind, ma_len, ma_data, ma_data_valid,
		ma_frame_valid, generate_nak, nak_reason);
endinterface

// Slave bus, one per device
interface sl_bus_if import ice_bus_pkg::*; ();
	logic      sl_request;
	ice_char_t sl_data;
	logic      sl_last;
	logic      sl_grant;
	logic      sl_data_latch;

	modport device (output sl_request, sl_data, sl_last, input sl_grant, sl_data_latch);
	modport arbiter (input sl_request, sl_data, sl_last, output sl_grant, sl_data_latch);
endinterface

// ==== design/ice_bus_pkg.sv ====
package ice_bus_pkg;

	// One byte on the host link or a bus
	typedef logic [7:0] ice_char_t;

	// Frame kind, decoded once at the length byte
	typedef enum logic [1:0] {
		KIND_QUERY = 2'd0,
		KIND_ECHO  = 2'd1,
		KIND_NAK   = 2'd2
	} frame_kind_e;

	// Reason code, sent as the third NAK byte
	typedef enum logic [7:0] {
		NAK_BAD_ADDR = 8'd1,
		NAK_TOO_LONG = 8'd2
	} nak_reason_e;

	// One queued NAK
	// Address of the bad frame in the upper byte
	typedef struct packed {
		ice_char_t   addr;
		nak_reason_e reason;
	} nak_rec_t;

endpackage

// ==== design/ice_bus_top.sv ====
`timescale 1ns/100ps
`include "ice_bus_consts.svh"

module ice_bus_top
	import ice_bus_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	// Host receive side, one strobe per byte
	input  ice_char_t rx_char,
	input  logic      rx_char_valid,
	// Host transmit side
	output ice_char_t tx_char,
	output logic      tx_char_valid,
	input  logic      tx_char_ready
);

	// Master bus, broadcast to every device
	ma_bus_if ma_bus ();

	// Slave buses, index is the device number and its priority
	sl_bus_if sl_bus [`ICE_NUM_DEV] ();

	// Host bytes to frames
	frame_parser u_parser (
		.clk          (clk),
		.rst_n        (rst_n),
		.rx_char      (rx_char),
		.rx_char_valid(rx_char_valid),
		.ma           (ma_bus)
	);

	// Device 0, query and echo
	basics_responder u_basics (
		.clk  (clk),
		.rst_n(rst_n),
		.ma   (ma_bus),
		.sl   (sl_bus[0])
	);

	// Device 1, NAKs for bad frames
	nak_responder u_nak (
		.clk  (clk),
		.rst_n(rst_n),
		.ma   (ma_bus),
		.sl   (sl_bus[1])
	);

	// Responses back to the host
	resp_arbiter u_arbiter (
		.clk          (clk),
		.rst_n        (rst_n),
		.sl           (sl_bus),
		.tx_char      (tx_char),
		.tx_char_valid(tx_char_valid),
		.tx_char_ready(tx_char_ready)
	);

endmodule

// ==== design/ice_fifo.sv ====
`timescale 1ns/100ps

module ice_fifo #(
	parameter type item_t = logic [7:0],
	parameter int  DEPTH  = 4
) (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  push,
	input  item_t push_item,
	input  logic  pop,
	output item_t head,
	output logic  empty,
	output logic  full
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	item_t mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic do_push;
	logic do_pop;

	// Push when full is dropped, pop when empty ignored
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign empty = (count == '0);
	assign full  = (count == CW'(DEPTH));
	assign head  = mem[rd_ptr];

	// Storage
	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_item;
	end

	// Pointers wrap at DEPTH, which need not be a power of two
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

endmodule

// ==== design/nak_responder.sv ====
`timescale 1ns/100ps
`include "ice_bus_consts.svh"

module nak_responder
	import ice_bus_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	ma_bus_if.device ma,
	sl_bus_if.device sl
);

	nak_rec_t   head;
	nak_rec_t   new_rec;
	logic       empty;
	logic       full;
	logic       req;
	logic [1:0] idx;
	logic       take;

	// Record built from the header, valid with generate_nak
	assign new_rec = '{addr: ma.ma_addr, reason: ma.nak_reason};

	// Pending NAKs
	// Extra NAKs beyond the depth are lost
	ice_fifo #(
		.item_t(nak_rec_t),
		.DEPTH (`ICE_NAK_DEPTH)
	) u_nak_fifo (
		.clk      (clk),
		.rst_n    (rst_n),
		.push     (ma.generate_nak && !full),
		.push_item(new_rec),
		.pop      (take && sl.sl_last),
		.head     (head),
		.empty    (empty),
		.full     (full)
	);

	assign take          = sl.sl_grant && sl.sl_data_latch;
	assign sl.sl_request = req;
	assign sl.sl_last    = (idx == 2'd2);

	// 'N', address, reason
	always_comb begin
		case (idx)
			2'd0:    sl.sl_data = `ICE_NAK_CHAR;
			2'd1:    sl.sl_data = head.addr;
			default: sl.sl_data = head.reason;
		endcase
	end

	// Request drops after each record, one idle cycle before the next
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req <= 1'b0;
			idx <= '0;
		end else if (take) begin
			if (sl.sl_last) begin
				req <= 1'b0;
				idx <= '0;
			end else begin
				idx <= idx + 2'd1;
			end
		end else if (!req && !empty) begin
			req <= 1'b1;
		end
	end

endmodule

// ==== design/resp_arbiter.sv ====
`timescale 1ns/100ps
`include "ice_bus_consts.svh"

module resp_arbiter
	import ice_bus_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	sl_bus_if.arbiter sl [`ICE_NUM_DEV],
	output ice_char_t tx_char,
	output logic      tx_char_valid,
	input  logic      tx_char_ready
);

	localparam int GW = (`ICE_NUM_DEV > 1) ? $clog2(`ICE_NUM_DEV) : 1;

	logic [`ICE_NUM_DEV-1:0]      req_vec;
	logic [`ICE_NUM_DEV-1:0]      last_vec;
	ice_char_t [`ICE_NUM_DEV-1:0] data_vec;
	logic [GW-1:0]                grant_idx;
	logic [GW-1:0]                pick;
	logic                         busy;
	logic                         latch;

	// Flatten the bus array, grant and latch go to one device only
	for (genvar g = 0; g < `ICE_NUM_DEV; g++) begin : g_dev
		assign req_vec[g]          = sl[g].sl_request;
		assign last_vec[g]         = sl[g].sl_last;
		assign data_vec[g]         = sl[g].sl_data;
		assign sl[g].sl_grant      = busy && (grant_idx == GW'(g));
		assign sl[g].sl_data_latch = latch && (grant_idx == GW'(g));
	end

	// Lowest requesting index wins
	always_comb begin
		pick = '0;
		for (int i = `ICE_NUM_DEV - 1; i >= 0; i--) begin
			if (req_vec[i])
				pick = GW'(i);
		end
	end

	// One byte per ready cycle, latch and tx strobe together
	assign latch         = busy && req_vec[grant_idx] && tx_char_ready;
	assign tx_char       = data_vec[grant_idx];
	assign tx_char_valid = latch;

	// Grant held until the last byte is taken
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy      <= 1'b0;
			grant_idx <= '0;
		end else if (!busy) begin
			if (|req_vec) begin
				busy      <= 1'b1;
				grant_idx <= pick;
			end
		end else if (latch && last_vec[grant_idx]) begin
			busy <= 1'b0;
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, then decide on the log contents
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f tb.f --top-module ice_bus_tb -o ice_bus_sim \
	&& ./obj_dir/ice_bus_sim > sim.log 2>&1 \
	|| echo "Build or simulation ended with an error"
cat sim.log 2>/dev/null
grep -q "All tests passed!" sim.log \
	&& { echo "Simulation result: PASS"; exit 0; } \
	|| { echo "Simulation result: FAIL"; exit 1; }

// ==== tb.f ====
+incdir+design
design/ice_bus_pkg.sv
design/ice_bus_if.sv
design/ice_fifo.sv
design/frame_parser.sv
design/basics_responder.sv
design/nak_responder.sv
design/resp_arbiter.sv
design/ice_bus_top.sv
verif/ice_bus_chk.sv
verif/ice_bus_tb.sv

// ==== verif/ice_bus_chk.sv ====
`timescale 1ns/100ps

module ice_bus_chk (
	input logic       clk,
	input logic       rst_n,
	input logic       tx_char_valid,
	input logic       tx_char_ready,
	// One grant bit per device
	input logic [1:0] sl_grant,
	input logic       ma_data_valid,
	input logic       ma_frame_valid
);

	// Failures seen so far, read by the testbench at the end
	int fail_count = 0;

	// No tx strobe while the host is not ready
	a_tx_ready: assert property (@(posedge clk) disable iff (!rst_n)
		tx_char_valid |-> tx_char_ready)
		else begin
			$error("tx_char_valid while tx_char_ready is low");
			fail_count++;
		end

	// Slave bus owned by one device at most
	a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(sl_grant))
		else begin
			$error("more than one sl_grant high");
			fail_count++;
		end

	// Payload strobes stay inside their frame
	a_data_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
		ma_data_valid |-> ma_frame_valid)
		else begin
			$error("ma_data_valid outside ma_frame_valid");
			fail_count++;
		end

endmodule

bind ice_bus_top ice_bus_chk u_chk (
	.clk           (clk),
	.rst_n         (rst_n),
	.tx_char_valid (tx_char_valid),
	.tx_char_ready (tx_char_ready),
	.sl_grant      ({sl_bus[1].sl_grant, sl_bus[0].sl_grant}),
	.ma_data_valid (ma_bus.ma_data_valid),
	.ma_frame_valid(ma_bus.ma_frame_valid)
);

// ==== verif/ice_bus_input.txt ====
// Columns: frame byte count, frame bytes, response byte count, response bytes
// A frame byte count of 00 ends the list
// Query
02 56 00  04 56 02 13 02
// Echo, lengths 0, 1 and 15
02 45 00  02 45 00
03 45 01 a5  03 45 01 a5
11 45 0f 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f
11 45 0f 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f
// Unknown address, payload swallowed
05 41 03 11 22 33  03 4e 41 01
02 00 00  03 4e 00 01
// Length 16 on echo and query
12 45 10 00 11 22 33 44 55 66 77 88 99 aa bb cc dd ee ff  03 4e 45 02
12 56 10 f0 f1 f2 f3 f4 f5 f6 f7 f8 f9 fa fb fc fd fe ff  03 4e 56 02
// Normal frames after the NAKs
06 45 04 de ad be ef  06 45 04 de ad be ef
02 56 00  04 56 02 13 02
00

// ==== verif/ice_bus_tb.sv ====
`timescale 1ns/100ps

module ice_bus_tb
	import ice_bus_pkg::*;
();

	localparam int MEM_WORDS      = 256;
	localparam int TIMEOUT_CYCLES = 2000;
	localparam int QUIET_CYCLES   = 16;

	logic      clk;
	logic      rst_n;
	ice_char_t rx_char;
	logic      rx_char_valid;
	ice_char_t tx_char;
	logic      tx_char_valid;
	logic      tx_char_ready;

	// Records from the data file
	ice_char_t stim [MEM_WORDS];
	// Bytes seen on the tx side
	ice_char_t got_q [$];
	int        errors = 0;
	int        timeouts = 0;

	ice_bus_top DUT (
		.clk          (clk),
		.rst_n        (rst_n),
		.rx_char      (rx_char),
		.rx_char_valid(rx_char_valid),
		.tx_char      (tx_char),
		.tx_char_valid(tx_char_valid),
		.tx_char_ready(tx_char_ready)
	);

	// 8 ns clock
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Host not ready on about one cycle in four
	initial begin
		tx_char_ready = 1'b0;
		forever begin
			@(negedge clk);
			tx_char_ready = rst_n && ($urandom_range(3, 0) != 0);
		end
	end

	// Response bytes captured at the rising edge
	always @(posedge clk) begin
		if (rst_n && tx_char_valid)
			got_q.push_back(tx_char);
	end

	// One response byte against the file
	task automatic check_char(input ice_char_t got, input ice_char_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s got 8'h%h, expected 8'h%h",
				$time, what, got, exp);
		end
	endtask

	// Response length against the file
	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %0d bytes, expected %0d",
				$time, what, got, exp);
		end
	endtask

	// One rx strobe after 0 to 3 idle cycles
	// Called on a falling edge
	task automatic send_char(input ice_char_t c);
		int gap;
		gap = int'($urandom_range(3, 0));
		repeat (gap) @(negedge clk);
		rx_char       = c;
		rx_char_valid = 1'b1;
		@(negedge clk);
		rx_char_valid = 1'b0;
	endtask

	// Wait until count bytes have arrived
	task automatic wait_response(input int count, input int rec, output bit timed_out);
		int cycles;
		cycles = 0;
		while (got_q.size() < count && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			cycles++;
		end
		timed_out = (got_q.size() < count);
		if (timed_out) begin
			timeouts++;
			$display("ERROR at %0t: response timed out for record %0d", $time, rec);
		end
	endtask

	initial begin
		int p;
		int rec;
		int n_frame;
		int n_resp;
		bit timed_out;
		// Times printed in ns
		$timeformat(-9, 1, " ns", 0);
		rst_n         = 1'b0;
		rx_char       = '0;
		rx_char_valid = 1'b0;
		void'($urandom(32'h5d48_eb1d));
		$readmemh("verif/ice_bus_input.txt", stim);
		// Reset for 8 cycles
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		repeat (2) @(negedge clk);
		p         = 0;
		rec       = 0;
		timed_out = 1'b0;
		// A frame byte count of zero ends the list
		while (!timed_out && p < MEM_WORDS && stim[p] != 8'h00) begin
			n_frame = int'(stim[p]);
			for (int i = 1; i <= n_frame; i++)
				send_char(stim[p + i]);
			// Response count, then the expected bytes
			p      = p + n_frame + 1;
			n_resp = int'(stim[p]);
			wait_response(n_resp, rec, timed_out);
			// Extra bytes would show up here
			if (!timed_out)
				repeat (QUIET_CYCLES) @(negedge clk);
			check_count(got_q.size(), n_resp, $sformatf("record %0d", rec));
			for (int i = 0; i < n_resp && i < got_q.size(); i++)
				check_char(got_q[i], stim[p + 1 + i], $sformatf("record %0d byte %0d", rec, i));
			got_q.delete();
			p   = p + n_resp + 1;
			rec = rec + 1;
		end
		$display("Records run: %0d, check errors: %0d, timeouts: %0d, assertion errors: %0d",
			rec, errors, timeouts, DUT.u_chk.fail_count);
		if (errors == 0 && timeouts == 0 && DUT.u_chk.fail_count == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule
